// File: all.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/inst_decode.sv
verilog/operand_select.sv
verilog/execute_unit.sv
verilog/reg_file.sv
verilog/pipe_ctrl.sv
verilog/pipe_core.sv
bench/core_chk.sv
bench/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/core_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import isa_pkg::*;
();

    localparam int ROM_WORDS  = 64;
    localparam int EXIT_LIMIT = 2000;

    logic            clk;
    logic            rst_n_i;
    logic            inst_valid_i;
    logic [XLEN-1:0] inst_addr_i;
    logic [XLEN-1:0] inst_i;
    logic            inst_ready_o;
    logic            redirect_valid_o;
    logic [XLEN-1:0] redirect_addr_o;
    logic            retire_valid_o;
    logic [XLEN-1:0] retire_pc_o;
    logic [4:0]      retire_rd_o;
    logic [XLEN-1:0] retire_data_o;
    logic [XLEN-1:0] gp_o;
    logic            exit_o;

    logic [XLEN-1:0] rom [ROM_WORDS];
    logic [XLEN-1:0] mreg [NREG];
    int              ret_cnt [ROM_WORDS];
    logic [XLEN-1:0] ret_data [ROM_WORDS];
    logic [4:0]      ret_rd [ROM_WORDS];
    logic [XLEN-1:0] redir_q [$];
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] exp_arith;
    logic [XLEN-1:0] exp_gp;
    logic            fire_next;
    int              withheld;
    int              stalls;
    int              errors;
    int              tests_run;
    int              tests_failed;
    int              cycles;

    pipe_core pipe_core_i (.*);

    always #5 clk = ~clk;

    // fill words are nops whose immediate follows the address
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        logic [11:0] imm;
        imm = addr[13:2] ^ addr[25:14] ^ {4'b0, addr[31:26], addr[1:0]};
        return {imm, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] rom_word(input logic [XLEN-1:0] addr);
        if (addr[31:2] < ROM_WORDS) begin
            return rom[addr[7:2]];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [XLEN-1:0] enc_b(input int off, input int rs2, input int rs1,
                                              input logic [2:0] f3);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] enc_j(input int off, input int rd);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd[4:0], OPC_JAL};
    endfunction

    // R-type op, reference register model follows along
    task automatic emit_r(input int idx, input logic [6:0] f7, input logic [2:0] f3,
                          input int rd, input int rs1, input int rs2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        a = mreg[rs1];
        b = mreg[rs2];
        rom[idx] = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
        case (f3)
            F3_XOR:  res = a ^ b;
            F3_OR:   res = a | b;
            F3_AND:  res = a & b;
            default: res = (f7 == F7_SUB) ? a - b : a + b;
        endcase
        if (rd != 0) mreg[rd] = res;
    endtask

    task automatic emit_addi(input int idx, input int rd, input int rs1, input int imm);
        rom[idx] = {imm[11:0], rs1[4:0], F3_ADD_SUB, rd[4:0], OPC_OP_IMM};
        if (rd != 0) mreg[rd] = mreg[rs1] + 32'(imm);
    endtask

    task automatic emit_lui(input int idx, input int rd, input int imm20);
        rom[idx] = {imm20[19:0], rd[4:0], OPC_LUI};
        if (rd != 0) mreg[rd] = {imm20[19:0], 12'b0};
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = fill_word(32'(i * 4));
        for (int i = 0; i < NREG; i++) mreg[i] = '0;
        emit_addi(0, 1, 0, 5);
        emit_addi(1, 2, 1, 7);
        emit_r(2, 7'd0, F3_ADD_SUB, 3, 1, 2);
        emit_r(3, F7_SUB, F3_ADD_SUB, 4, 3, 1);
        emit_r(4, 7'd0, F3_XOR, 5, 4, 3);
        emit_r(5, 7'd0, F3_OR, 6, 5, 1);
        emit_r(6, 7'd0, F3_AND, 7, 6, 2);
        emit_lui(7, 8, 20'h12345);
        emit_r(8, 7'd0, F3_ADD_SUB, 3, 7, 8);
        exp_arith = mreg[3];
        // taken beq skips two poison words
        rom[9]  = enc_b(12, 1, 1, F3_BEQ);
        rom[10] = {12'hfff, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM};
        rom[11] = {12'hfff, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM};
        rom[12] = enc_j(12, 9);
        rom[13] = {12'hfff, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM};
        rom[14] = {12'hfff, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM};
        rom[15] = enc_b(8, 1, 1, F3_BNE);
        emit_addi(16, 3, 3, 1);
        rom[17] = INST_ECALL;
        exp_gp = mreg[3];
    endtask

    // fetch source, inputs change on the falling edge only
    initial begin
        void'($urandom(32'hf1f5));
        forever begin
            @(negedge clk);
            if (!rst_n_i) begin
                inst_valid_i = 1'b0;
                fetch_pc     = '0;
                fire_next    = 1'b0;
            end else begin
                if (redirect_valid_o) begin
                    fetch_pc     = redirect_addr_o;
                    inst_valid_i = 1'b0;
                end else begin
                    if (fire_next) fetch_pc = fetch_pc + 32'd4;
                    if (!(inst_valid_i && !fire_next)) begin
                        inst_valid_i = ($urandom % 4) != 0;
                        if (!inst_valid_i) withheld++;
                    end
                end
                inst_addr_i = fetch_pc;
                inst_i      = rom_word(fetch_pc);
                fire_next   = inst_valid_i && inst_ready_o;
                if (inst_valid_i && !inst_ready_o && !exit_o) stalls++;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n_i && retire_valid_o && retire_pc_o[31:2] < ROM_WORDS) begin
            ret_cnt[retire_pc_o[7:2]]++;
            ret_data[retire_pc_o[7:2]] = retire_data_o;
            ret_rd[retire_pc_o[7:2]]   = retire_rd_o;
        end
        if (rst_n_i && redirect_valid_o) redir_q.push_back(redirect_addr_o);
    end

    task automatic check_results();
        int e;
        e = errors;
        for (int i = 0; i <= 8; i++) begin
            check_value($sformatf("retire count pc %0d", i * 4), 1, ret_cnt[i]);
        end
        check_value("retire_data_o (add x3)", exp_arith, ret_data[8]);
        end_test("dependent arithmetic", e);
        e = errors;
        check_value("redirect count", 2, redir_q.size());
        if (redir_q.size() == 2) begin
            check_value("redirect_addr_o (beq)", 32'd36 + 32'd12, redir_q[0]);
            check_value("redirect_addr_o (jal)", 32'd48 + 32'd12, redir_q[1]);
        end
        foreach (ret_cnt[i]) begin
            if (i == 10 || i == 11 || i == 13 || i == 14) begin
                check_value($sformatf("poison retire pc %0d", i * 4), 0, ret_cnt[i]);
            end
        end
        check_value("retire_rd_o (jal)", 9, ret_rd[12]);
        check_value("retire_data_o (jal)", 32'd48 + 32'd4, ret_data[12]);
        end_test("taken branch and jal", e);
        e = errors;
        check_value("retire count bne", 1, ret_cnt[15]);
        check_value("retire count after bne", 1, ret_cnt[16]);
        end_test("not-taken branch", e);
        e = errors;
        if (withheld == 0) begin
            $display("inst_valid_i was never withheld, back-pressure not exercised");
            errors++;
        end
        if (stalls == 0) begin
            $display("inst_ready_o never went low while an instruction was waiting");
            errors++;
        end
        end_test($sformatf("back-pressure (%0d withheld, %0d stalled cycles)",
                           withheld, stalls), e);
        e = errors;
        check_value("exit_o", 1, exit_o);
        check_value("inst_ready_o", 0, inst_ready_o);
        check_value("gp_o", exp_gp, gp_o);
        check_value("retire count ecall", 1, ret_cnt[17]);
        end_test("exit", e);
    endtask

    initial begin
        int e;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_addr_i  = '0;
        inst_i       = INST_NOP;
        errors       = 0;
        withheld     = 0;
        stalls       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < ROM_WORDS; i++) ret_cnt[i] = 0;
        build_program();
        repeat (8) @(negedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        e = errors;
        check_value("inst_ready_o", 1, inst_ready_o);
        check_value("redirect_valid_o", 0, redirect_valid_o);
        check_value("retire_valid_o", 0, retire_valid_o);
        check_value("exit_o", 0, exit_o);
        end_test("reset state", e);
        cycles = 0;
        while (!exit_o && cycles < EXIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit_o) begin
            $display("timeout: exit_o did not rise within %0d cycles", EXIT_LIMIT);
            $display("TEST FAILED");
        end else begin
            // exit has to stay up while fetch stays closed
            repeat (10) @(negedge clk);
            check_results();
            $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                     tests_run, tests_failed, errors, pipe_core_i.chk_i.fail_cnt);
            if (errors == 0 && pipe_core_i.chk_i.fail_cnt == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

// File: bench/core_chk.sv
`timescale 1ns/1ps

module core_chk
    import isa_pkg::*;
(
    input logic            clk,
    input logic            rst_n_i,
    input logic            inst_valid_i,
    input logic            inst_ready_o,
    input logic            redirect_valid_o,
    input logic            retire_valid_o,
    input logic [XLEN-1:0] retire_pc_o,
    input logic [4:0]      retire_rd_o,
    input logic            retire_wen_i,
    input logic            exit_o
);

    int              fail_cnt = 0;
    logic            retired_any;
    logic [XLEN-1:0] last_pc;
    logic            quiet;

    assign quiet = !redirect_valid_o && !retire_valid_o && !exit_o;

    // last retired pc, for the ordering check
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retired_any <= 1'b0;
            last_pc     <= '0;
        end else if (retire_valid_o) begin
            retired_any <= 1'b1;
            last_pc     <= retire_pc_o;
        end
    end

    // covers the reset cycles and the first cycle after release
    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> quiet ##1 quiet)
        else begin
            $error("outputs active during or right after reset");
            fail_cnt++;
        end

    retire_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_valid_o && retire_wen_i) |-> retire_rd_o != '0)
        else begin
            $error("register write retired to x0");
            fail_cnt++;
        end

    single_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_o |=> !redirect_valid_o)
        else begin
            $error("redirect held for two cycles");
            fail_cnt++;
        end

    // a stall lasts one cycle, the held instruction goes in next
    stall_released: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_valid_i && !inst_ready_o && !exit_o) |=> (inst_ready_o || exit_o))
        else begin
            $error("fetch stall longer than one cycle");
            fail_cnt++;
        end

    retire_in_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_valid_o && retired_any) |-> retire_pc_o > last_pc)
        else begin
            $error("retire pc out of order");
            fail_cnt++;
        end

    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        exit_o |-> (!inst_ready_o ##1 exit_o))
        else begin
            $error("exit dropped or fetch reopened after exit");
            fail_cnt++;
        end

endmodule

bind pipe_core core_chk chk_i (
    .clk(clk), .rst_n_i(rst_n_i),
    .inst_valid_i(inst_valid_i), .inst_ready_o(inst_ready_o),
    .redirect_valid_o(redirect_valid_o),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_rd_o(retire_rd_o), .retire_wen_i(wb_pay.ctrl.rf_wen),
    .exit_o(exit_o)
);

// File: verilog/pipe_core.sv
`timescale 1ns/1ps

module pipe_core
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  logic [XLEN-1:0]   inst_addr_i,
    input  logic [XLEN-1:0]   inst_i,
    output logic              inst_ready_o,
    output logic              redirect_valid_o,
    output logic [XLEN-1:0]   redirect_addr_o,
    output logic              retire_valid_o,
    output logic [XLEN-1:0]   retire_pc_o,
    output logic [REG_AW-1:0] retire_rd_o,
    output logic [XLEN-1:0]   retire_data_o,
    output logic [XLEN-1:0]   gp_o,
    output logic              exit_o
);

    logic            hold_id;
    logic            hold_ds;
    logic            flush_id;
    logic            flush_ds;
    logic            flush_ex;
    logic            inst_fire;
    logic            id_valid;
    logic            ds_valid;
    logic            ex_valid;
    logic            wb_valid;
    id_pay_t         id_in;
    id_pay_t         id_pay;
    ds_pay_t         ds_in;
    ds_pay_t         ds_pay;
    ex_pay_t         ex_in;
    ex_pay_t         ex_pay;
    wb_pay_t         wb_in;
    wb_pay_t         wb_pay;
    ctrl_t           id_ctrl;
    logic [XLEN-1:0] id_imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            ds_hazard;
    logic            ds_stall;
    logic            next_valid;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] ex_target;
    logic            mispredict;
    logic            wb_wen;

    assign inst_fire = inst_valid_i && inst_ready_o;
    assign id_in     = '{pc: inst_addr_i, inst: inst_i};
    assign ds_in     = '{pc: id_pay.pc, ctrl: id_ctrl, imm: id_imm};
    assign ex_in     = '{pc: ds_pay.pc, ctrl: ds_pay.ctrl, imm: ds_pay.imm, op1: op1, op2: op2};
    assign wb_in     = '{pc: ex_pay.pc, ctrl: ex_pay.ctrl, result: ex_result};

    assign ds_stall   = ds_valid && ds_hazard;
    // nearest younger instruction checks the prediction
    assign next_valid = ds_valid || id_valid;
    assign next_pc    = ds_valid ? ds_pay.pc : id_pay.pc;
    assign wb_wen     = wb_valid && wb_pay.ctrl.rf_wen;

    assign retire_valid_o = wb_valid;
    assign retire_pc_o    = wb_pay.pc;
    assign retire_rd_o    = wb_pay.ctrl.rd;
    assign retire_data_o  = wb_pay.result;

    stage_reg #(.payload_t(id_pay_t)) id_reg (
        .clk(clk), .rst_n_i(rst_n_i), .hold_i(hold_id), .flush_i(flush_id),
        .valid_i(inst_fire), .pay_i(id_in), .valid_o(id_valid), .pay_o(id_pay)
    );

    inst_decode decode_i (.inst_i(id_pay.inst), .ctrl_o(id_ctrl), .imm_o(id_imm));

    stage_reg #(.payload_t(ds_pay_t)) ds_reg (
        .clk(clk), .rst_n_i(rst_n_i), .hold_i(hold_ds), .flush_i(flush_ds),
        .valid_i(id_valid), .pay_i(ds_in), .valid_o(ds_valid), .pay_o(ds_pay)
    );

    operand_select opsel_i (
        .ctrl_i(ds_pay.ctrl), .imm_i(ds_pay.imm),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_valid_i(ex_valid), .ex_rd_i(ex_pay.ctrl.rd), .ex_wen_i(ex_pay.ctrl.rf_wen),
        .wb_valid_i(wb_valid), .wb_rd_i(wb_pay.ctrl.rd), .wb_wen_i(wb_pay.ctrl.rf_wen),
        .wb_data_i(wb_pay.result),
        .op1_o(op1), .op2_o(op2), .hazard_o(ds_hazard)
    );

    stage_reg #(.payload_t(ex_pay_t)) ex_reg (
        .clk(clk), .rst_n_i(rst_n_i), .hold_i(1'b0), .flush_i(flush_ex),
        .valid_i(ds_valid), .pay_i(ex_in), .valid_o(ex_valid), .pay_o(ex_pay)
    );

    execute_unit exec_i (
        .valid_i(ex_valid), .pay_i(ex_pay),
        .next_valid_i(next_valid), .next_pc_i(next_pc),
        .result_o(ex_result), .mispredict_o(mispredict), .target_o(ex_target)
    );

    stage_reg #(.payload_t(wb_pay_t)) wb_reg (
        .clk(clk), .rst_n_i(rst_n_i), .hold_i(1'b0), .flush_i(1'b0),
        .valid_i(ex_valid), .pay_i(wb_in), .valid_o(wb_valid), .pay_o(wb_pay)
    );

    reg_file rf_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .we_i(wb_wen), .waddr_i(wb_pay.ctrl.rd), .wdata_i(wb_pay.result),
        .raddr1_i(ds_pay.ctrl.rs1), .raddr2_i(ds_pay.ctrl.rs2),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data), .gp_o(gp_o)
    );

    pipe_ctrl ctrl_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .ds_hazard_i(ds_stall), .mispredict_i(mispredict), .target_i(ex_target),
        .wb_valid_i(wb_valid), .wb_exit_i(wb_pay.ctrl.is_exit),
        .hold_id_o(hold_id), .hold_ds_o(hold_ds),
        .flush_id_o(flush_id), .flush_ds_o(flush_ds), .flush_ex_o(flush_ex),
        .inst_ready_o(inst_ready_o),
        .redirect_valid_o(redirect_valid_o), .redirect_addr_o(redirect_addr_o),
        .exit_o(exit_o)
    );

endmodule

// File: verilog/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl
    import isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            ds_hazard_i,
    input  logic            mispredict_i,
    input  logic [XLEN-1:0] target_i,
    input  logic            wb_valid_i,
    input  logic            wb_exit_i,
    output logic            hold_id_o,
    output logic            hold_ds_o,
    output logic            flush_id_o,
    output logic            flush_ds_o,
    output logic            flush_ex_o,
    output logic            inst_ready_o,
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_addr_o,
    output logic            exit_o
);

    // id and ds wait one cycle for the exe result
    assign hold_id_o  = ds_hazard_i;
    assign hold_ds_o  = ds_hazard_i;
    assign flush_ex_o = mispredict_i || ds_hazard_i || exit_o;
    assign flush_ds_o = mispredict_i || exit_o;
    // also drops whatever is accepted during the redirect cycle
    assign flush_id_o = mispredict_i || redirect_valid_o || exit_o;

    assign inst_ready_o = !exit_o && !ds_hazard_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            redirect_valid_o <= 1'b0;
            exit_o           <= 1'b0;
        end else begin
            redirect_valid_o <= mispredict_i;
            exit_o           <= exit_o || (wb_valid_i && wb_exit_i);
        end
    end

    // registered so execute never reaches fetch combinationally
    always_ff @(posedge clk) begin
        redirect_addr_o <= target_i;
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic [REG_AW-1:0] raddr1_i,
    input  logic [REG_AW-1:0] raddr2_i,
    output logic [XLEN-1:0]   rdata1_o,
    output logic [XLEN-1:0]   rdata2_o,
    output logic [XLEN-1:0]   gp_o
);

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];
    assign gp_o     = regs[REG_GP];

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic            valid_i,
    input  ex_pay_t         pay_i,
    input  logic            next_valid_i,
    input  logic [XLEN-1:0] next_pc_i,
    output logic [XLEN-1:0] result_o,
    output logic            mispredict_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] seq_pc;
    logic            taken;

    always_comb begin
        case (pay_i.ctrl.alu_op)
            ALU_ADD: alu_out = pay_i.op1 + pay_i.op2;
            ALU_SUB: alu_out = pay_i.op1 - pay_i.op2;
            ALU_AND: alu_out = pay_i.op1 & pay_i.op2;
            ALU_OR:  alu_out = pay_i.op1 | pay_i.op2;
            ALU_XOR: alu_out = pay_i.op1 ^ pay_i.op2;
            default: alu_out = pay_i.op2;
        endcase
    end

    // branch compare next to the alu
    always_comb begin
        case (pay_i.ctrl.br_kind)
            BR_EQ:   taken = pay_i.op1 == pay_i.op2;
            BR_NE:   taken = pay_i.op1 != pay_i.op2;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign seq_pc   = pay_i.pc + XLEN'(4);
    assign result_o = (pay_i.ctrl.wb_sel == WB_PC4) ? seq_pc : alu_out;
    assign target_o = taken ? pay_i.pc + pay_i.imm : seq_pc;

    // prediction is always pc+4
    // with nothing younger in flight only a taken branch has to redirect
    assign mispredict_o = valid_i && (next_valid_i ? next_pc_i != target_o : taken);

endmodule

// File: verilog/operand_select.sv
`timescale 1ns/1ps

module operand_select
    import isa_pkg::*, pipe_pkg::*;
(
    input  ctrl_t             ctrl_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    input  logic              ex_valid_i,
    input  logic [REG_AW-1:0] ex_rd_i,
    input  logic              ex_wen_i,
    input  logic              wb_valid_i,
    input  logic [REG_AW-1:0] wb_rd_i,
    input  logic              wb_wen_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic [XLEN-1:0]   op1_o,
    output logic [XLEN-1:0]   op2_o,
    output logic              hazard_o
);

    logic            ex_writes;
    logic            wb_writes;
    logic [XLEN-1:0] rs2_val;

    assign ex_writes = ex_valid_i && ex_wen_i && ex_rd_i != '0;
    assign wb_writes = wb_valid_i && wb_wen_i && wb_rd_i != '0;

    // writeback result overrides the not yet written register
    assign op1_o   = (wb_writes && wb_rd_i == ctrl_i.rs1) ? wb_data_i : rs1_data_i;
    assign rs2_val = (wb_writes && wb_rd_i == ctrl_i.rs2) ? wb_data_i : rs2_data_i;
    assign op2_o   = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : rs2_val;

    // exe result is not forwarded, wait until it sits in writeback
    assign hazard_o = ex_writes && (ex_rd_i == ctrl_i.rs1 || ex_rd_i == ctrl_i.rs2);

endmodule

// File: verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic [XLEN-1:0] inst_i,
    output ctrl_t           ctrl_o,
    output logic [XLEN-1:0] imm_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              legal;
    logic              writes;
    logic              use_rs1;
    logic              use_rs2;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    always_comb begin
        ctrl_o  = '0;
        legal   = 1'b0;
        writes  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                legal   = funct7 == '0 || (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
                writes  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    F3_ADD_SUB: ctrl_o.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:     ctrl_o.alu_op = ALU_XOR;
                    F3_OR:      ctrl_o.alu_op = ALU_OR;
                    F3_AND:     ctrl_o.alu_op = ALU_AND;
                    default:    legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // only addi
                legal          = funct3 == F3_ADD_SUB;
                writes         = 1'b1;
                use_rs1        = 1'b1;
                ctrl_o.op2_sel = OP2_IMM;
            end
            OPC_LUI: begin
                legal          = 1'b1;
                writes         = 1'b1;
                ctrl_o.alu_op  = ALU_PASS_B;
                ctrl_o.op2_sel = OP2_IMM;
            end
            OPC_BRANCH: begin
                legal          = funct3 == F3_BEQ || funct3 == F3_BNE;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl_o.br_kind = (funct3 == F3_BNE) ? BR_NE : BR_EQ;
            end
            OPC_JAL: begin
                legal          = 1'b1;
                writes         = 1'b1;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.br_kind = BR_JAL;
            end
            OPC_SYSTEM: begin
                legal          = inst_i == INST_ECALL;
                ctrl_o.is_exit = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // unused sources read as x0 so they never raise a hazard
        ctrl_o.rs1    = use_rs1 ? rs1 : '0;
        ctrl_o.rs2    = use_rs2 ? rs2 : '0;
        ctrl_o.rd     = writes ? rd : '0;
        ctrl_o.rf_wen = writes && rd != '0;
        if (!legal) begin
            ctrl_o = '0;
        end
    end

    always_comb begin
        case (opcode)
            OPC_LUI:    imm_o = {inst_i[31:12], 12'b0};
            OPC_BRANCH: imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            OPC_JAL:    imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            default:    imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
        endcase
    end

endmodule

// File: verilog/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t pay_i,
    output logic     valid_o,
    output payload_t pay_o
);

    // flush beats hold
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            pay_o <= pay_i;
        end
    end

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    typedef struct packed {
        alu_op_e           alu_op;
        op2_sel_e          op2_sel;
        wb_sel_e           wb_sel;
        br_kind_e          br_kind;
        logic              rf_wen;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic              is_exit;
    } ctrl_t;

    // id stage payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } id_pay_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        ctrl_t           ctrl;
        logic [XLEN-1:0] imm;
    } ds_pay_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        ctrl_t           ctrl;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
    } ex_pay_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        ctrl_t           ctrl;
        logic [XLEN-1:0] result;
    } wb_pay_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

    localparam int XLEN   = 32;
    localparam int NREG   = 32;
    localparam int REG_AW = $clog2(NREG);
    localparam int REG_GP = 3;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] INST_NOP   = 32'h0000_0013;
    // ecall ends the run
    localparam logic [XLEN-1:0] INST_ECALL = 32'h0000_0073;

endpackage
